// ==== all.f ====
common/cpu_pkg.sv
common/ctrl_if.sv
rtl/alu.sv
rtl/register_file.sv
rtl/pc_unit.sv
rtl/controller.sv
rtl/cpu.sv
bench/cpu_tb.sv

// ==== bench/cpu_tb.sv ====
module cpu_tb import cpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam word_t marker_adr = 32'h0000_03fc; // end-of-test store address

  logic  clk;
  logic  rst;
  word_t imem_adr;
  word_t imem_data;
  word_t dmem_adr;
  word_t dmem_wdata;
  logic  dmem_wen;
  word_t dmem_rdata;

  word_t  imem [64];
  word_t  dmem [256];
  word_t  ref_mem [256];  // model copy of data memory
  word_t  ref_regs [32];
  word_t  ref_pc;
  integer seed;
  int     passes;
  int     errs;
  int     test_errs;      // failures inside the running test
  int     test_no;
  int     cycles;
  int     limit;
  int     halt_cycles;
  string  names [6] = '{"arith", "load_store", "branch", "call", "reg_zero", "reset_halt"};

  cpu cpu_i (
    .clk        (clk),
    .rst        (rst),
    .imem_adr   (imem_adr),
    .imem_data  (imem_data),
    .dmem_adr   (dmem_adr),
    .dmem_wdata (dmem_wdata),
    .dmem_wen   (dmem_wen),
    .dmem_rdata (dmem_rdata)
  );

  always #10 clk = ~clk;

  // word addressed combinational reads
  assign imem_data  = imem[imem_adr[7:2]];
  assign dmem_rdata = dmem[dmem_adr[9:2]];

  always @(posedge clk) begin
    if (dmem_wen)
      dmem[dmem_adr[9:2]] <= dmem_wdata;
  end

  // isa model stepping one instruction per call
  function automatic word_t ref_step(output logic st, output word_t sadr, output word_t sdata);
    instr_t   ins;
    word_t    rs;
    word_t    rt;
    word_t    imm_s;
    word_t    imm_z;
    word_t    nxt;
    word_t    res;
    word_t    adr;
    logic     wr;
    reg_idx_t wa;
    ins   = imem[ref_pc[7:2]];
    rs    = ref_regs[ins.r.rs];
    rt    = ref_regs[ins.r.rt];
    imm_s = {{16{ins.i.imm[15]}}, ins.i.imm};
    imm_z = {16'h0000, ins.i.imm};  // andi/ori
    adr   = rs + imm_s;
    nxt   = ref_pc + 32'd4;
    st    = 1'b0;
    sadr  = '0;
    sdata = '0;
    wr    = 1'b0;
    wa    = ins.i.rt;
    res   = '0;
    case (ins.r.opcode)
      op_rtype: begin
        wr = 1'b1;
        wa = ins.r.rd;
        case (ins.r.funct)
          fn_add: res = rs + rt;
          fn_sub: res = rs - rt;
          fn_and: res = rs & rt;
          fn_or:  res = rs | rt;
          fn_slt: res = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
          fn_sll: res = rt << ins.r.shamt;
          fn_jr: begin
            wr  = 1'b0;
            nxt = rs;
          end
          default: wr = 1'b0;
        endcase
      end
      op_j:    nxt = {nxt[31:28], ins.j.target, 2'b00};
      op_jal: begin
        wr  = 1'b1;
        wa  = 5'd31;
        res = nxt;  // link is pc+4
        nxt = {nxt[31:28], ins.j.target, 2'b00};
      end
      op_beq:  if (rs == rt) nxt = nxt + (imm_s << 2);
      op_bne:  if (rs != rt) nxt = nxt + (imm_s << 2);
      op_addi: begin
        wr  = 1'b1;
        res = rs + imm_s;
      end
      op_andi: begin
        wr  = 1'b1;
        res = rs & imm_z;
      end
      op_ori: begin
        wr  = 1'b1;
        res = rs | imm_z;
      end
      op_lw: begin
        wr  = 1'b1;
        res = ref_mem[adr[9:2]];
      end
      op_sw: begin
        st    = 1'b1;
        sadr  = adr;
        sdata = rt;
        ref_mem[adr[9:2]] = rt;
      end
      default: ; // unknown opcode acts as nop
    endcase
    if (wr && wa != 5'd0)
      ref_regs[wa] = res;
    ref_pc = nxt;
    return nxt;
  endfunction

  task automatic reset_model();
    ref_pc = reset_vector;
    for (int n = 0; n < 32; n++)
      ref_regs[n] = '0;
    for (int n = 0; n < 256; n++)
      ref_mem[n] = dmem[n];
  endtask

  task automatic note_failure(string what);
    $display("%s in test %s", what, names[test_no]);
    errs++;
    test_errs++;
  endtask

  task automatic check_pc(word_t expected, word_t actual);
    if (expected !== actual) begin
      $display("ERROR %s pc expected %h actual %h", names[test_no], expected, actual);
      errs++;
      test_errs++;
    end else passes++;
  endtask

  task automatic check_store(word_t exp_adr, word_t exp_data);
    if (exp_adr !== dmem_adr || exp_data !== dmem_wdata) begin
      $display("ERROR %s store expected %h <- %h actual %h <- %h", names[test_no],
               exp_adr, exp_data, dmem_adr, dmem_wdata);
      errs++;
      test_errs++;
    end else passes++;
  endtask

  task automatic finish_test();
    $display("test %0d %s: %s", test_no + 1, names[test_no], (test_errs == 0) ? "ok" : "bad");
    test_errs = 0;
    if (test_no < 5)
      test_no++;
  endtask

  task automatic report();
    $display("passed %0d failed %0d", passes, errs);
    if (errs == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  endtask

  initial begin
    word_t p;
    word_t nxt;
    logic  st;
    word_t sadr;
    word_t sdata;
    int    n;
    seed = 32'h949e;
    clk  = 1'b0;
    rst  = 1'b1;
    passes = 0;
    errs = 0;
    test_errs = 0;
    test_no = 0;
    cycles = 0;
    halt_cycles = 0;
    for (int i = 0; i < 64; i++)
      imem[i] = '0;
    $readmemh("bench/program.hex", imem);
    for (int i = 0; i < 256; i++)
      dmem[i] = (i < 16) ? $random(seed) : (32'hd0d0_0000 | i); // rest tagged by address
    // dry run to the halt loop sizes the timeout
    reset_model();
    n = 0;
    do begin
      p   = ref_pc;
      nxt = ref_step(st, sadr, sdata);
      n++;
    end while (nxt != p && n < 1000);
    limit = 4 * n + 20;
    reset_model();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  end

  // compares pre-edge values on every edge
  always @(posedge clk) begin : compare
    logic  st;
    word_t sadr;
    word_t sdata;
    word_t prev_pc;
    word_t nxt;
    if (rst) begin
      if (dmem_wen)
        note_failure("store issued while reset is high");
    end else begin
      cycles++;
      prev_pc = ref_pc;
      check_pc(ref_pc, imem_adr); // first one is reset_vector
      nxt = ref_step(st, sadr, sdata);
      if (st && dmem_wen)
        check_store(sadr, sdata);
      else if (st)
        note_failure("model stores but the DUT does not");
      else if (dmem_wen)
        note_failure("DUT stores but the model does not");
      if ((st && sadr == marker_adr) || (dmem_wen && dmem_adr == marker_adr))
        finish_test();
      if (nxt == prev_pc) begin
        halt_cycles++; // j to self holds the pc
        if (halt_cycles == 3) begin
          if (test_no != 5)
            note_failure("halt loop reached before all tests finished");
          finish_test();
          report();
        end
      end else if (cycles > limit) begin
        $display("timeout after %0d cycles, halt loop never reached", cycles);
        $display("CHECKS FAILED");
        $finish;
      end
    end
  end

endmodule

// ==== bench/program.hex ====
// one instruction word per line, word address 0 upward
// arith: addi addi add sub slt sll andi ori and or, stores, marker
2001FFFB
20020007
00221820
00222022
0022282A
000230C0
3027F0F0
34281234
00224824
00225025
AC030040
AC040044
AC050048
AC06004C
AC070050
AC080054
AC090058
AC0A005C
AC0003FC
// load_store: lw lw add sw addi sw(base) marker
8C0B0000
8C0C0004
016C6820
AC0D0060
200E0080
ADCD0008
AC0003FC
// branch: counted loop of 3, beq exit, bne back, bne not taken
200F0003
20100000
22100001
120F0001
1600FFFD
160F0001
AC100068
AC0003FC
// call: jal to word 41, store link, marker
0C000029
AC1F006C
AC0003FC
// reg_zero: write r0, store r0, marker
20000009
AC000070
AC0003FC
// halt loop at word 40, jr subroutine at word 41
08000028
03E00008

// ==== common/cpu_pkg.sv ====
package cpu_pkg;

  typedef logic [31:0] word_t;    // data, address or instruction
  typedef logic [4:0]  reg_idx_t; // register number

  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_j     = 6'h02,
    op_jal   = 6'h03,
    op_beq   = 6'h04,
    op_bne   = 6'h05,
    op_addi  = 6'h08,
    op_andi  = 6'h0c,
    op_ori   = 6'h0d,
    op_lw    = 6'h23,
    op_sw    = 6'h2b
  } opcode_t;

  // funct field of r-type
  typedef enum logic [5:0] {
    fn_sll = 6'h00,
    fn_jr  = 6'h08,
    fn_add = 6'h20,
    fn_sub = 6'h22,
    fn_and = 6'h24,
    fn_or  = 6'h25,
    fn_slt = 6'h2a
  } funct_t;

  typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_sll} alu_op_t;

  typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump, pc_reg} pc_sel_t;
  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc4} wb_sel_t;
  typedef enum logic [1:0] {wadr_rd, wadr_rt, wadr_ra} wadr_sel_t;

  // one instruction word, three formats
  typedef union packed {
    struct packed {
      opcode_t  opcode;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      reg_idx_t shamt;
      funct_t   funct;
    } r;
    struct packed {
      opcode_t     opcode;
      reg_idx_t    rs;
      reg_idx_t    rt;
      logic [15:0] imm;
    } i;
    struct packed {
      opcode_t     opcode;
      logic [25:0] target;
    } j;
  } instr_t;

  localparam word_t    reset_vector = 32'h0000_0000;
  localparam reg_idx_t reg_ra       = 5'd31; // link register for jal

endpackage

// ==== common/ctrl_if.sv ====
interface ctrl_if import cpu_pkg::*; ();

  pc_sel_t   pc_sel;   // next pc source
  wb_sel_t   wb_sel;   // register write data source
  wadr_sel_t wadr_sel; // register write address source
  alu_op_t   alu_op;
  logic      sel_imm;  // alu b from immediate
  logic      sgn_ext;  // sign extend, else zero extend
  logic      shift;    // alu a from rt, for sll
  logic      rf_wen;
  logic      dm_wen;

  // controller side
  modport ctrl (
    output pc_sel, wb_sel, wadr_sel, alu_op, sel_imm, sgn_ext, shift, rf_wen, dm_wen
  );

  // datapath side
  modport dp (
    input pc_sel, wb_sel, wadr_sel, alu_op, sel_imm, sgn_ext, shift, rf_wen, dm_wen
  );

endinterface

// ==== rtl/alu.sv ====
module alu import cpu_pkg::*; (
  input  word_t    a,
  input  word_t    b,
  input  reg_idx_t shamt,
  input  alu_op_t  op,
  output word_t    result,
  output logic     zero
);

  word_t sum;
  word_t diff;

  assign sum  = a + b;
  assign diff = a - b; // also feeds beq/bne via zero

  always_comb begin
    case (op)
      alu_add: result = sum;
      alu_sub: result = diff;
      alu_and: result = a & b;
      alu_or:  result = a | b;
      alu_slt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0; // signed compare
      alu_sll: result = a << shamt;
      default: result = sum;
    endcase
  end

  assign zero = (result == '0);

endmodule

// ==== rtl/controller.sv ====
module controller import cpu_pkg::*; (
  input  instr_t instr,
  input  logic   zero, // alu result was zero
  input  logic   rst,
  ctrl_if.ctrl   c
);

  // main decode, independent of the alu flag
  always_comb begin
    c.wb_sel   = wb_alu;
    c.wadr_sel = wadr_rd;
    c.alu_op   = alu_add;
    c.sel_imm  = 1'b0;
    c.sgn_ext  = 1'b1;
    c.shift    = 1'b0;
    c.rf_wen   = 1'b0;
    c.dm_wen   = 1'b0;
    case (instr.r.opcode)
      op_rtype: begin
        c.rf_wen = 1'b1;
        case (instr.r.funct)
          fn_add: c.alu_op = alu_add;
          fn_sub: c.alu_op = alu_sub;
          fn_and: c.alu_op = alu_and;
          fn_or:  c.alu_op = alu_or;
          fn_slt: c.alu_op = alu_slt;
          fn_sll: begin
            c.alu_op = alu_sll;
            c.shift  = 1'b1; // shifts rt, not rs
          end
          default: c.rf_wen = 1'b0; // jr and unknown funct write nothing
        endcase
      end
      op_jal: begin
        c.rf_wen   = 1'b1;
        c.wadr_sel = wadr_ra;
        c.wb_sel   = wb_pc4; // link address
      end
      op_beq, op_bne: c.alu_op = alu_sub; // compare via zero flag
      op_addi, op_andi, op_ori, op_lw: begin
        c.rf_wen   = 1'b1;
        c.wadr_sel = wadr_rt;
        c.sel_imm  = 1'b1;
        if (instr.i.opcode == op_andi) begin
          c.alu_op  = alu_and;
          c.sgn_ext = 1'b0;
        end else if (instr.i.opcode == op_ori) begin
          c.alu_op  = alu_or;
          c.sgn_ext = 1'b0;
        end
        if (instr.i.opcode == op_lw)
          c.wb_sel = wb_mem;
      end
      op_sw: begin
        c.sel_imm = 1'b1; // base + offset
        c.dm_wen  = 1'b1;
      end
      default: ; // j and unknown opcodes: no writes
    endcase
    if (rst) begin
      c.rf_wen = 1'b0;
      c.dm_wen = 1'b0;
    end
  end

  // next pc source, branch resolved here
  always_comb begin
    case (instr.r.opcode)
      op_rtype: c.pc_sel = (instr.r.funct == fn_jr) ? pc_reg : pc_seq;
      op_j, op_jal: c.pc_sel = pc_jump;
      op_beq:   c.pc_sel = zero ? pc_branch : pc_seq;
      op_bne:   c.pc_sel = zero ? pc_seq : pc_branch;
      default:  c.pc_sel = pc_seq;
    endcase
  end

  // register and memory write never in the same instruction
  always_comb begin
    a_wen_excl: assert (!(c.rf_wen && c.dm_wen))
      else $error("rf_wen and dm_wen both high");
  end

endmodule

// ==== rtl/cpu.sv ====
module cpu import cpu_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  output word_t imem_adr,
  input  word_t imem_data,
  output word_t dmem_adr,
  output word_t dmem_wdata,
  output logic  dmem_wen,
  input  word_t dmem_rdata
);

  instr_t   instr;
  word_t    pc;
  word_t    pc_plus4;
  word_t    rs_data;
  word_t    rt_data;
  word_t    imm_ext;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_res;
  logic     alu_zero;
  reg_idx_t wadr;
  word_t    wdata;

  ctrl_if c ();

  assign instr = imem_data; // decoded through r, i and j views

  controller ctrl_i (
    .instr (instr),
    .zero  (alu_zero),
    .rst   (rst),
    .c     (c)
  );

  // extender, zero extend for andi/ori
  assign imm_ext = c.sgn_ext ? {{16{instr.i.imm[15]}}, instr.i.imm} : {16'b0, instr.i.imm};

  register_file rf_i (
    .clk     (clk),
    .rst     (rst),
    .rs_adr  (instr.r.rs),
    .rt_adr  (instr.r.rt),
    .wadr    (wadr),
    .wdata   (wdata),
    .wen     (c.rf_wen),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  assign alu_a = c.shift ? rt_data : rs_data;   // sll operates on rt
  assign alu_b = c.sel_imm ? imm_ext : rt_data;

  alu alu_i (
    .a      (alu_a),
    .b      (alu_b),
    .shamt  (instr.r.shamt),
    .op     (c.alu_op),
    .result (alu_res),
    .zero   (alu_zero)
  );

  pc_unit pc_i (
    .clk      (clk),
    .rst      (rst),
    .c        (c),
    .imm_ext  (imm_ext),
    .target   (instr.j.target),
    .rs_data  (rs_data),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  // write address and write-back data
  always_comb begin
    case (c.wadr_sel)
      wadr_rt: wadr = instr.i.rt;
      wadr_ra: wadr = reg_ra;
      default: wadr = instr.r.rd;
    endcase
    case (c.wb_sel)
      wb_mem:  wdata = dmem_rdata;
      wb_pc4:  wdata = pc_plus4; // jal link
      default: wdata = alu_res;
    endcase
  end

  assign imem_adr   = pc;
  assign dmem_adr   = alu_res; // base + offset
  assign dmem_wdata = rt_data;
  assign dmem_wen   = c.dm_wen;

endmodule

// ==== rtl/pc_unit.sv ====
module pc_unit import cpu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  ctrl_if.dp          c,
  input  word_t       imm_ext,  // extended branch offset
  input  logic [25:0] target,   // j/jal field
  input  word_t       rs_data,  // jr target
  output word_t       pc,
  output word_t       pc_plus4
);

  word_t pc_next;
  word_t br_target;
  word_t jmp_target;

  assign pc_plus4   = pc + 32'd4;
  assign br_target  = pc_plus4 + {imm_ext[29:0], 2'b00}; // word offset
  assign jmp_target = {pc_plus4[31:28], target, 2'b00};  // stays in 256MB region

  always_comb begin
    case (c.pc_sel)
      pc_branch: pc_next = br_target;
      pc_jump:   pc_next = jmp_target;
      pc_reg:    pc_next = rs_data;
      default:   pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)
      pc <= reset_vector; // held during reset
    else
      pc <= pc_next;
  end

  // catches a misaligned jr target one edge later
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
  ) else $error("pc not word aligned: %h", pc);

endmodule

// ==== rtl/register_file.sv ====
module register_file import cpu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs_adr,
  input  reg_idx_t rt_adr,
  input  reg_idx_t wadr,
  input  word_t    wdata,
  input  logic     wen,
  output word_t    rs_data,
  output word_t    rt_data
);

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int n = 0; n < 32; n++)
        regs[n] <= '0;
    end else if (wen && wadr != '0) begin // r0 stays zero
      regs[wadr] <= wdata;
    end
  end

  // combinational reads
  assign rs_data = regs[rs_adr];
  assign rt_data = regs[rt_adr];

  // r0 only stays zero if no write ever reached it
  a_r0_zero: assert property (
    @(posedge clk) disable iff (rst)
    (rs_adr != '0 || rs_data == '0) && (rt_adr != '0 || rt_data == '0)
  ) else $error("register 0 read back nonzero");

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f all.f --top-module cpu_tb -o cpu_sim
out=$(./obj_dir/cpu_sim)
echo "$out"
if echo "$out" | grep -q "ALL CHECKS PASSED"; then
  exit 0
else
  exit 1
fi
